// File: rtl/sparse_pe_pkg.sv
// Shared widths, APB bus structs, register map and command struct; import in every PE module
package sparse_pe_pkg;

    // ==================================================
    // Datapath and bus widths
    // ==================================================
    // Signed activation / weight element
    localparam int DATA_W = 8;
    // Signed partial sum, wraps at this width
    localparam int PSUM_W = 32;
    // APB address and data
    localparam int APB_AW = 12;
    localparam int APB_DW = 32;

    // ==================================================
    // APB request / response
    // ==================================================
    // Host side of the bus
    typedef struct packed {
        logic [APB_AW-1:0] paddr;
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [APB_DW-1:0] pwdata;
    } apb_req_t;

    // Slave side of the bus
    typedef struct packed {
        logic [APB_DW-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

    // Single-cycle command pulses to the row datapath
    typedef struct packed {
        logic start;
        logic row_end;
    } pe_cmd_t;

    // ==================================================
    // Register map, byte offsets
    // ==================================================
    localparam logic [APB_AW-1:0] REG_CTRL      = 12'h000;
    localparam logic [APB_AW-1:0] REG_ACT_FLAG  = 12'h004;
    localparam logic [APB_AW-1:0] REG_WEI_FLAG0 = 12'h008;
    localparam logic [APB_AW-1:0] REG_WEI_FLAG1 = 12'h00C;
    localparam logic [APB_AW-1:0] REG_WEI_FLAG2 = 12'h010;
    // Block windows, four lanes per word, lane 0 in low byte
    localparam logic [APB_AW-1:0] REG_ACT_BASE  = 12'h040;
    localparam logic [APB_AW-1:0] REG_WEI0_BASE = 12'h080;
    localparam logic [APB_AW-1:0] REG_WEI1_BASE = 12'h0C0;
    localparam logic [APB_AW-1:0] REG_WEI2_BASE = 12'h100;
    // Psum entry i at base + 4*i
    localparam logic [APB_AW-1:0] REG_PSUM_BASE = 12'h200;

endpackage

// File: rtl/psum_row_buf.sv
// Partial-sum row storage with an accumulate port for the datapath and a host access port
`timescale 1ns/1ps

module psum_row_buf
    import sparse_pe_pkg::*;
#(
    parameter int LENPSUM = 16
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       acc_en,
    input  logic [$clog2(LENPSUM)-1:0] acc_addr,
    input  logic signed [PSUM_W-1:0]   acc_val,
    input  logic                       host_we,
    input  logic [$clog2(LENPSUM)-1:0] host_addr,
    input  logic [PSUM_W-1:0]          host_wdata,
    output logic [PSUM_W-1:0]          host_rdata
);

    // ==================================================
    // Psum entries
    // ==================================================
    logic signed [PSUM_W-1:0] psum [LENPSUM];

    // Read-add-write from the row, overwrite from the host
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < LENPSUM; i++) begin
                psum[i] <= '0;
            end
        end else if (acc_en) begin
            // Wraps at psum width
            psum[acc_addr] <= psum[acc_addr] + acc_val;
        end else if (host_we) begin
            // Host writes are held off while busy, no overlap with acc_en
            psum[host_addr] <= host_wdata;
        end
    end

    // ==================================================
    // Host read
    // ==================================================
    // Combinational, muxed into prdata
    assign host_rdata = psum[host_addr];

endmodule

// File: rtl/sparse_mac.sv
// Flag-gated serial dot product over one operand block; one lane per cycle, done pulse at end
`timescale 1ns/1ps

module sparse_mac
    import sparse_pe_pkg::*;
#(
    parameter int BLOCK_DEPTH = 8
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               start,
    input  logic [BLOCK_DEPTH-1:0]             act_flag,
    input  logic [BLOCK_DEPTH-1:0][DATA_W-1:0] act_blk,
    input  logic [BLOCK_DEPTH-1:0]             wei_flag,
    input  logic [BLOCK_DEPTH-1:0][DATA_W-1:0] wei_blk,
    output logic                               done,
    output logic signed [PSUM_W-1:0]           mac
);

    localparam int LANE_W = $clog2(BLOCK_DEPTH);

    logic                       run;
    logic [LANE_W-1:0]          lane;
    logic                       hit;
    logic signed [2*DATA_W-1:0] prod;
    logic signed [PSUM_W-1:0]   prod_ext;
    logic signed [PSUM_W-1:0]   acc;

    // ==================================================
    // Current lane product
    // ==================================================
    always_comb begin
        // Idle counter sits at lane 0 for the start cycle
        hit      = act_flag[lane] & wei_flag[lane];
        prod     = signed'(act_blk[lane]) * signed'(wei_blk[lane]);
        // Sign extend to psum width
        prod_ext = prod;
    end

    // ==================================================
    // Lane walk and accumulate
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run  <= 1'b0;
            lane <= '0;
            acc  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                // Restart with the sum seeded by lane 0
                acc  <= hit ? prod_ext : '0;
                lane <= LANE_W'(1);
                run  <= 1'b1;
            end else if (run) begin
                // Zero-flagged lanes skip the add
                if (hit) begin
                    acc <= acc + prod_ext;
                end
                if (lane == LANE_W'(BLOCK_DEPTH - 1)) begin
                    run  <= 1'b0;
                    lane <= '0;
                    done <= 1'b1;
                end else begin
                    lane <= lane + 1'b1;
                end
            end
        end
    end

    // Held until the next start
    assign mac = acc;

endmodule

// File: rtl/cnv_row.sv
// One convolution row: three sparse MACs, completion join and down-counting psum position
`timescale 1ns/1ps

module cnv_row
    import sparse_pe_pkg::*;
#(
    parameter int BLOCK_DEPTH = 8,
    parameter int LENPSUM     = 16
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  pe_cmd_t                                 cmd,
    input  logic [BLOCK_DEPTH-1:0]                  act_flag,
    input  logic [BLOCK_DEPTH-1:0][DATA_W-1:0]      act_blk,
    input  logic [2:0][BLOCK_DEPTH-1:0]             wei_flag,
    input  logic [2:0][BLOCK_DEPTH-1:0][DATA_W-1:0] wei_blk,
    output logic                                    row_done,
    output logic                                    acc_en,
    output logic [$clog2(LENPSUM)-1:0]              acc_addr,
    output logic signed [PSUM_W-1:0]                acc_val
);

    localparam int PSUM_AW = $clog2(LENPSUM);

    logic [2:0]               mac_done;
    logic signed [PSUM_W-1:0] mac_res [3];
    logic [2:0]               fin_q;
    logic                     join_all;
    logic [PSUM_AW-1:0]       pos;

    // ==================================================
    // Kernel row MACs, activation block shared
    // ==================================================
    for (genvar k = 0; k < 3; k++) begin : g_mac
        sparse_mac #(
            .BLOCK_DEPTH (BLOCK_DEPTH)
        ) u_sparse_mac (
            .clk      (clk),
            .rst_n    (rst_n),
            .start    (cmd.start),
            .act_flag (act_flag),
            .act_blk  (act_blk),
            .wei_flag (wei_flag[k]),
            .wei_blk  (wei_blk[k]),
            .done     (mac_done[k]),
            .mac      (mac_res[k])
        );
    end

    // All three finished, counting this cycle's pulses
    assign join_all = &(fin_q | mac_done);

    // ==================================================
    // Completion join and accumulate issue
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fin_q  <= '0;
            acc_en <= 1'b0;
        end else begin
            acc_en <= join_all;
            if (cmd.start || join_all) begin
                fin_q <= '0;
            end else begin
                fin_q <= fin_q | mac_done;
            end
        end
    end

    // Row sum, consumed with acc_en one cycle later
    always_ff @(posedge clk) begin
        acc_val <= mac_res[0] + mac_res[1] + mac_res[2];
    end

    // ==================================================
    // Row position, counts down and wraps
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pos <= PSUM_AW'(LENPSUM - 1);
        end else if (cmd.row_end) begin
            pos <= PSUM_AW'(LENPSUM - 1);
        end else if (acc_en) begin
            pos <= pos - 1'b1;
        end
    end

    assign acc_addr = pos;
    // Row finishes with its accumulate
    assign row_done = acc_en;

endmodule

// File: rtl/pe_ctrl.sv
// APB slave and control point of the PE; holds operands, issues commands, tracks busy
`timescale 1ns/1ps

module pe_ctrl
    import sparse_pe_pkg::*;
#(
    parameter int BLOCK_DEPTH = 8,
    parameter int LENPSUM     = 16
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  apb_req_t                                apb_req,
    output apb_rsp_t                                apb_rsp,
    output logic [BLOCK_DEPTH-1:0]                  act_flag,
    output logic [BLOCK_DEPTH-1:0][DATA_W-1:0]      act_blk,
    output logic [2:0][BLOCK_DEPTH-1:0]             wei_flag,
    output logic [2:0][BLOCK_DEPTH-1:0][DATA_W-1:0] wei_blk,
    output pe_cmd_t                                 cmd,
    input  logic                                    row_done,
    output logic                                    host_we,
    output logic [$clog2(LENPSUM)-1:0]              host_addr,
    output logic [PSUM_W-1:0]                       host_wdata,
    input  logic [PSUM_W-1:0]                       host_rdata
);

    // Words per block window
    localparam int WORDS    = BLOCK_DEPTH / 4;
    localparam int PSUM_AW  = $clog2(LENPSUM);
    // First byte past the psum window
    localparam int PSUM_END = int'(REG_PSUM_BASE) + 4 * LENPSUM;

    // ==================================================
    // Address decode
    // ==================================================
    logic              access;
    logic [3:0]        word_idx;
    logic [5:0]        lane_base;
    logic              blk_ok;
    logic              sel_ctrl;
    logic              sel_aflag;
    logic              sel_act;
    logic              sel_psum;
    logic [2:0]        sel_wflag;
    logic [2:0]        sel_wblk;
    logic              mapped;
    logic              stall;
    logic              wr_done;
    logic              busy;
    logic [APB_DW-1:0] rdata;

    always_comb begin
        access    = apb_req.psel & apb_req.penable;
        word_idx  = apb_req.paddr[5:2];
        // First lane held by the addressed word
        lane_base = {word_idx, 2'b00};
        blk_ok    = (apb_req.paddr[1:0] == 2'b00) && (int'(word_idx) < WORDS);

        sel_ctrl     = apb_req.paddr == REG_CTRL;
        sel_aflag    = apb_req.paddr == REG_ACT_FLAG;
        sel_wflag[0] = apb_req.paddr == REG_WEI_FLAG0;
        sel_wflag[1] = apb_req.paddr == REG_WEI_FLAG1;
        sel_wflag[2] = apb_req.paddr == REG_WEI_FLAG2;

        // Block windows are 64 bytes, so match on the upper address bits
        sel_act     = blk_ok && (apb_req.paddr[11:6] == REG_ACT_BASE[11:6]);
        sel_wblk[0] = blk_ok && (apb_req.paddr[11:6] == REG_WEI0_BASE[11:6]);
        sel_wblk[1] = blk_ok && (apb_req.paddr[11:6] == REG_WEI1_BASE[11:6]);
        sel_wblk[2] = blk_ok && (apb_req.paddr[11:6] == REG_WEI2_BASE[11:6]);

        sel_psum = (apb_req.paddr[1:0] == 2'b00)
                && (apb_req.paddr >= REG_PSUM_BASE)
                && (int'(apb_req.paddr) < PSUM_END);

        mapped = sel_ctrl | sel_aflag | sel_act | sel_psum | (|sel_wflag) | (|sel_wblk);

        // Back-pressure: new start or psum write must wait for the row to finish
        stall = busy & apb_req.pwrite
              & ((sel_ctrl & apb_req.pwdata[0]) | sel_psum);

        wr_done = access & ~stall & apb_req.pwrite & mapped;
    end

    // ==================================================
    // Read mux and response
    // ==================================================
    always_comb begin
        rdata = '0;
        if (sel_ctrl) begin
            rdata = APB_DW'(busy);
        end else if (sel_aflag) begin
            rdata = APB_DW'(act_flag);
        end else if (sel_act) begin
            rdata = act_blk[lane_base +: 4];
        end else if (sel_psum) begin
            rdata = host_rdata;
        end else begin
            // Weight flags and blocks, at most one selected
            for (int k = 0; k < 3; k++) begin
                if (sel_wflag[k]) begin
                    rdata = APB_DW'(wei_flag[k]);
                end
                if (sel_wblk[k]) begin
                    rdata = wei_blk[k][lane_base +: 4];
                end
            end
        end
    end

    assign apb_rsp.prdata  = rdata;
    assign apb_rsp.pready  = access & ~stall;
    // Unmapped offsets fail, no side effect
    assign apb_rsp.pslverr = access & ~stall & ~mapped;

    // Psum window goes straight to the buffer host port
    assign host_we    = wr_done & sel_psum;
    assign host_addr  = apb_req.paddr[2 +: PSUM_AW];
    assign host_wdata = apb_req.pwdata;

    // ==================================================
    // Operand registers
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            act_flag <= '0;
            act_blk  <= '0;
            wei_flag <= '0;
            wei_blk  <= '0;
        end else if (wr_done) begin
            if (sel_aflag) begin
                act_flag <= apb_req.pwdata[BLOCK_DEPTH-1:0];
            end
            if (sel_act) begin
                act_blk[lane_base +: 4] <= apb_req.pwdata;
            end
            for (int k = 0; k < 3; k++) begin
                if (sel_wflag[k]) begin
                    wei_flag[k] <= apb_req.pwdata[BLOCK_DEPTH-1:0];
                end
                if (sel_wblk[k]) begin
                    wei_blk[k][lane_base +: 4] <= apb_req.pwdata;
                end
            end
        end
    end

    // ==================================================
    // Command pulses and busy
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd  <= '0;
            busy <= 1'b0;
        end else begin
            // Start only completes when idle, stall guarantees that
            cmd.start   <= wr_done & sel_ctrl & apb_req.pwdata[0];
            // Row end dropped while a row is in flight
            cmd.row_end <= wr_done & sel_ctrl & apb_req.pwdata[1] & ~busy;
            if (wr_done & sel_ctrl & apb_req.pwdata[0]) begin
                busy <= 1'b1;
            end else if (row_done) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

// File: rtl/sparse_pe_top.sv
// Top level of the sparse convolution PE; APB in, control wired to the row datapath and psums
`timescale 1ns/1ps

module sparse_pe_top
    import sparse_pe_pkg::*;
#(
    parameter int BLOCK_DEPTH = 8,
    parameter int LENPSUM     = 16
) (
    input  logic     clk,
    input  logic     rst_n,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp
);

    localparam int PSUM_AW = $clog2(LENPSUM);

    // ==================================================
    // Control to datapath
    // ==================================================
    logic [BLOCK_DEPTH-1:0]                  act_flag;
    logic [BLOCK_DEPTH-1:0][DATA_W-1:0]      act_blk;
    logic [2:0][BLOCK_DEPTH-1:0]             wei_flag;
    logic [2:0][BLOCK_DEPTH-1:0][DATA_W-1:0] wei_blk;
    pe_cmd_t                                 cmd;
    logic                                    row_done;
    // Accumulate port
    logic                                    acc_en;
    logic [PSUM_AW-1:0]                      acc_addr;
    logic signed [PSUM_W-1:0]                acc_val;
    // Host psum port
    logic                                    host_we;
    logic [PSUM_AW-1:0]                      host_addr;
    logic [PSUM_W-1:0]                       host_wdata;
    logic [PSUM_W-1:0]                       host_rdata;

    pe_ctrl #(.BLOCK_DEPTH(BLOCK_DEPTH), .LENPSUM(LENPSUM)) u_pe_ctrl (
        .clk(clk), .rst_n(rst_n), .apb_req(apb_req), .apb_rsp(apb_rsp),
        .act_flag(act_flag), .act_blk(act_blk), .wei_flag(wei_flag), .wei_blk(wei_blk),
        .cmd(cmd), .row_done(row_done), .host_we(host_we), .host_addr(host_addr),
        .host_wdata(host_wdata), .host_rdata(host_rdata)
    );

    cnv_row #(.BLOCK_DEPTH(BLOCK_DEPTH), .LENPSUM(LENPSUM)) u_cnv_row (
        .clk(clk), .rst_n(rst_n), .cmd(cmd),
        .act_flag(act_flag), .act_blk(act_blk), .wei_flag(wei_flag), .wei_blk(wei_blk),
        .row_done(row_done), .acc_en(acc_en), .acc_addr(acc_addr), .acc_val(acc_val)
    );

    psum_row_buf #(.LENPSUM(LENPSUM)) u_psum_row_buf (
        .clk(clk), .rst_n(rst_n), .acc_en(acc_en), .acc_addr(acc_addr), .acc_val(acc_val),
        .host_we(host_we), .host_addr(host_addr), .host_wdata(host_wdata),
        .host_rdata(host_rdata)
    );

endmodule

// File: dv/sparse_pe_tb.sv
// Self-checking testbench for the sparse PE; drives APB, models the psum row, compares reads
`timescale 1ns/1ps

module sparse_pe_tb
    import sparse_pe_pkg::*;
();

    localparam int BLOCK_DEPTH = 8;
    localparam int LENPSUM     = 16;
    localparam int TIMEOUT     = 64;

    // One APB read waiting for comparison
    typedef struct packed {
        logic [31:0] got;
        logic [31:0] expd;
        logic        got_err;
        logic        exp_err;
    } rd_chk_t;

    logic     clk;
    logic     rst_n;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    logic [15:0] lfsr;

    // ==================================================
    // Model of operands and the psum row
    // ==================================================
    logic [BLOCK_DEPTH-1:0]                  m_aflag;
    logic [2:0][BLOCK_DEPTH-1:0]             m_wflag;
    logic [BLOCK_DEPTH-1:0][DATA_W-1:0]      m_act;
    logic [2:0][BLOCK_DEPTH-1:0][DATA_W-1:0] m_wei;
    logic [31:0] m_psum [LENPSUM];
    int          m_pos;
    rd_chk_t     chk_q [$];
    string       name_q [$];
    int          n_checks;
    int          n_errors;

    sparse_pe_top #(.BLOCK_DEPTH(BLOCK_DEPTH), .LENPSUM(LENPSUM)) u_sparse_pe_top (
        .clk(clk), .rst_n(rst_n), .apb_req(apb_req), .apb_rsp(apb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ==================================================
    // Random bits and reference model
    // ==================================================
    // x^16 + x^14 + x^13 + x^11
    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    // Masked dot product over three kernel rows, wraps at 32 bits
    function automatic logic [31:0] ref_dot();
        logic signed [31:0] sum;
        logic signed [31:0] a;
        logic signed [31:0] w;
        sum = '0;
        for (int k = 0; k < 3; k++) begin
            for (int i = 0; i < BLOCK_DEPTH; i++) begin
                if (m_aflag[i] && m_wflag[k][i]) begin
                    a   = $signed(m_act[i]);
                    w   = $signed(m_wei[k][i]);
                    sum = sum + a * w;
                end
            end
        end
        return sum;
    endfunction

    function automatic logic [11:0] psum_addr(input int i);
        return REG_PSUM_BASE + 12'(4 * i);
    endfunction

    // ==================================================
    // APB access
    // ==================================================
    task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err, output int waits);
        @(negedge clk);
        apb_req.paddr   = addr;
        apb_req.pwrite  = wr;
        apb_req.pwdata  = wdata;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        @(negedge clk);
        apb_req.penable = 1'b1;
        waits = 0;
        // Sample ready just after the falling edge
        #1;
        while (!apb_rsp.pready && waits < TIMEOUT) begin
            @(negedge clk);
            #1;
            waits++;
        end
        if (!apb_rsp.pready) begin
            $display("APB access to 0x%03h never completed", addr);
            n_errors++;
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        int          waits;
        apb_xfer(1'b1, addr, data, rd, err, waits);
        if (err) begin
            $display("write to 0x%03h returned a slave error", addr);
            n_errors++;
        end
    endtask

    // Read and queue for the compare process
    task automatic check_read(input logic [11:0] addr, input logic [31:0] expd,
                              input logic exp_err, input string name);
        rd_chk_t     c;
        logic [31:0] rd;
        logic        err;
        int          waits;
        apb_xfer(1'b0, addr, '0, rd, err, waits);
        c.got     = rd;
        c.got_err = err;
        c.expd    = expd;
        c.exp_err = exp_err;
        chk_q.push_back(c);
        name_q.push_back(name);
    endtask

    task automatic check_psum(input int i);
        check_read(psum_addr(i), m_psum[i], 1'b0, $sformatf("prdata psum[%0d]", i));
    endtask

    task automatic wait_idle();
        logic [31:0] rd;
        logic        err;
        int          waits;
        int          polls;
        rd    = 32'h1;
        polls = 0;
        while (rd[0] && polls < TIMEOUT) begin
            apb_xfer(1'b0, REG_CTRL, '0, rd, err, waits);
            polls++;
        end
        if (rd[0]) begin
            $display("busy never cleared after a start");
            n_errors++;
        end
    endtask

    // ==================================================
    // Operands and commands
    // ==================================================
    task automatic new_operands(input logic dense);
        if (dense) begin
            m_aflag = '1;
            m_wflag = '1;
        end else begin
            m_aflag = BLOCK_DEPTH'(rand_bits(BLOCK_DEPTH));
            for (int k = 0; k < 3; k++) begin
                m_wflag[k] = BLOCK_DEPTH'(rand_bits(BLOCK_DEPTH));
            end
        end
        for (int i = 0; i < BLOCK_DEPTH; i++) begin
            m_act[i] = 8'(rand_bits(8));
            for (int k = 0; k < 3; k++) begin
                m_wei[k][i] = 8'(rand_bits(8));
            end
        end
    endtask

    task automatic load_operands();
        apb_write(REG_ACT_FLAG, 32'(m_aflag));
        for (int k = 0; k < 3; k++) begin
            apb_write(REG_WEI_FLAG0 + 12'(4 * k), 32'(m_wflag[k]));
        end
        // Four lanes per word
        for (int w = 0; w < BLOCK_DEPTH / 4; w++) begin
            apb_write(REG_ACT_BASE + 12'(4 * w), m_act[4*w +: 4]);
            for (int k = 0; k < 3; k++) begin
                apb_write(REG_WEI0_BASE + 12'(64 * k + 4 * w), m_wei[k][4*w +: 4]);
            end
        end
    endtask

    // Row position steps down after each accumulate
    task automatic model_accumulate();
        m_psum[m_pos] = m_psum[m_pos] + ref_dot();
        m_pos = (m_pos + LENPSUM - 1) % LENPSUM;
    endtask

    task automatic run_start();
        apb_write(REG_CTRL, 32'h1);
        model_accumulate();
        wait_idle();
    endtask

    task automatic row_end();
        apb_write(REG_CTRL, 32'h2);
        m_pos = LENPSUM - 1;
    endtask

    // ==================================================
    // Compare process
    // ==================================================
    initial begin
        rd_chk_t c;
        string   nm;
        forever begin
            @(posedge clk);
            while (chk_q.size() > 0) begin
                c  = chk_q.pop_front();
                nm = name_q.pop_front();
                n_checks++;
                if (c.got != c.expd) begin
                    $display("mismatch %s: got 0x%08h expected 0x%08h", nm, c.got, c.expd);
                    n_errors++;
                end
                if (c.got_err != c.exp_err) begin
                    $display("mismatch pslverr (%s): got 0x%0h expected 0x%0h",
                             nm, c.got_err, c.exp_err);
                    n_errors++;
                end
            end
        end
    end

    // ==================================================
    // Stimulus
    // ==================================================
    initial begin
        logic [31:0] rd;
        logic [31:0] seed;
        logic        err;
        int          waits;
        int          cycles;
        int          q;
        apb_req  = '0;
        rst_n    = 1'b0;
        lfsr     = 16'd67;
        n_checks = 0;
        n_errors = 0;
        m_pos    = LENPSUM - 1;
        for (int i = 0; i < LENPSUM; i++) begin
            m_psum[i] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Reset state, register readback, unmapped offsets
        check_read(REG_CTRL, 32'h0, 1'b0, "prdata ctrl");
        for (int i = 0; i < LENPSUM; i++) begin
            check_psum(i);
        end
        new_operands(1'b0);
        load_operands();
        check_read(REG_ACT_FLAG, 32'(m_aflag), 1'b0, "prdata act_flag");
        for (int k = 0; k < 3; k++) begin
            check_read(REG_WEI_FLAG0 + 12'(4 * k), 32'(m_wflag[k]), 1'b0,
                       $sformatf("prdata wei_flag[%0d]", k));
        end
        for (int w = 0; w < BLOCK_DEPTH / 4; w++) begin
            check_read(REG_ACT_BASE + 12'(4 * w), m_act[4*w +: 4], 1'b0,
                       $sformatf("prdata act_blk word %0d", w));
            for (int k = 0; k < 3; k++) begin
                check_read(REG_WEI0_BASE + 12'(64 * k + 4 * w), m_wei[k][4*w +: 4], 1'b0,
                           $sformatf("prdata wei_blk[%0d] word %0d", k, w));
            end
        end
        check_read(12'h020, 32'h0, 1'b1, "prdata unmapped");
        apb_xfer(1'b1, 12'h3F0, 32'hDEAD_BEEF, rd, err, waits);
        if (!err) begin
            $display("write to an unmapped offset gave no slave error");
            n_errors++;
        end

        // Dense start, busy length from the start pulse
        new_operands(1'b1);
        load_operands();
        apb_write(REG_CTRL, 32'h1);
        cycles = 0;
        while (u_sparse_pe_top.u_pe_ctrl.busy && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles != BLOCK_DEPTH + 2) begin
            $display("mismatch busy_cycles: got 0x%0h expected 0x%0h", cycles, BLOCK_DEPTH + 2);
            n_errors++;
        end
        model_accumulate();
        check_psum(LENPSUM - 1);

        // Sparse flags onto seeded entries, one pass with no active lanes
        for (int n = 0; n < 4; n++) begin
            new_operands(1'b0);
            if (n == 1) begin
                m_aflag = '0;
            end
            load_operands();
            seed = rand_bits(32);
            apb_write(psum_addr(m_pos), seed);
            m_psum[m_pos] = seed;
            q = m_pos;
            run_start();
            check_psum(q);
        end

        // Fill the row downward past 0, then a second pass after row end
        row_end();
        for (int n = 0; n < LENPSUM + 2; n++) begin
            new_operands(1'b0);
            load_operands();
            run_start();
        end
        for (int i = 0; i < LENPSUM; i++) begin
            check_psum(i);
        end
        row_end();
        for (int n = 0; n < 4; n++) begin
            new_operands(1'b1);
            load_operands();
            run_start();
        end
        for (int i = 0; i < LENPSUM; i++) begin
            check_psum(i);
        end

        // Start and psum writes while busy are held off, then apply
        apb_write(REG_CTRL, 32'h1);
        model_accumulate();
        apb_xfer(1'b1, REG_CTRL, 32'h1, rd, err, waits);
        if (waits == 0 || err) begin
            $display("start written while busy was not stalled cleanly");
            n_errors++;
        end
        model_accumulate();
        seed = rand_bits(32);
        apb_xfer(1'b1, psum_addr(m_pos), seed, rd, err, waits);
        if (waits == 0 || err) begin
            $display("psum written while busy was not stalled cleanly");
            n_errors++;
        end
        m_psum[m_pos] = seed;
        run_start();
        for (int i = 0; i < LENPSUM; i++) begin
            check_psum(i);
        end

        // ==================================================
        // Summary
        // ==================================================
        waits = 0;
        while (chk_q.size() > 0 && waits < TIMEOUT) begin
            @(negedge clk);
            waits++;
        end
        if (chk_q.size() > 0) begin
            $display("reads were left uncompared at the end of the run");
            n_errors++;
        end
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: sparse_pe.f
rtl/sparse_pe_pkg.sv
rtl/psum_row_buf.sv
rtl/sparse_mac.sv
rtl/cnv_row.sv
rtl/pe_ctrl.sv
rtl/sparse_pe_top.sv
dv/sparse_pe_tb.sv

// File: Makefile
# Verilator build and run for the sparse PE testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing -Wno-fatal --top-module sparse_pe_tb -f sparse_pe.f
	@out="$$(./obj_dir/Vsparse_pe_tb)"; echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir
